// File: logic/game_config.svh
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// screen geometry in pixels
`define SCREEN_W 640
`define GROUND_Y 412

// dragon box, x is the centre column
`define DRAGON_X 120
`define DRAGON_W 88
`define DRAGON_H 94
`define DUCK_H 50

// single cactus standing on the ground
`define CACTUS_W 10
`define CACTUS_H 40
`define CACTUS_SPEED 4

// physics, pixels per frame
`define GRAVITY 2
`define JUMP_SHORT 10
`define JUMP_LONG 20

// space hold limits in frames
`define HOLD_SHORT_MAX 30
`define HOLD_MAX 60

// command queue between decode and motion
`define CMD_QUEUE_DEPTH 4

`endif

// File: logic/game_geom_pkg.sv
`default_nettype none

package game_geom_pkg;

  // screen coordinate, origin top left
  typedef logic [9:0] coordT;

  // vertical speed in pixels per frame
  // negative values move the dragon up
  typedef logic signed [7:0] motionT;

  // frames survived in the game state
  typedef logic [15:0] scoreT;

  // referee state machine
  typedef enum logic [1:0] {
    START,
    GAME,
    OVER
  } gameStateT;

  // dragon posture
  // JUMP whenever the dragon is off the ground
  typedef enum logic [1:0] {
    RUN,
    JUMP,
    DUCK
  } actionT;

endpackage

`default_nettype wire

// File: logic/game_input_pkg.sv
`default_nettype none

package game_input_pkg;

  // raw keyboard code, zero when no key is down
  typedef logic [7:0] scanCodeT;

  // keys the game reacts to
  typedef enum scanCodeT {
    KEY_RESTART = 8'h0d,
    KEY_SPACE   = 8'h20,
    KEY_DOWN    = 8'h26
  } keyCodeT;

  // commands sent from decode to motion
  typedef enum logic [2:0] {
    CMD_JUMP_SHORT,
    CMD_JUMP_LONG,
    CMD_DUCK_ON,
    CMD_DUCK_OFF,
    CMD_RESTART
  } cmdT;

endpackage

`default_nettype wire

// File: logic/cmd_link_if.sv
`timescale 1ns/1ns
`default_nettype none

// credit based command link
// sender starts with one credit per queue entry
interface cmd_link_if;

  // one command per cycle while valid is high
  logic                 cmdValid;
  game_input_pkg::cmdT  cmd;

  // one credit back per popped queue entry
  logic                 creditReturn;

  // decode side
  modport sender (
    output cmdValid,
    output cmd,
    input  creditReturn
  );

  // motion side, no ready needed since credits bound the queue
  modport receiver (
    input  cmdValid,
    input  cmd,
    output creditReturn
  );

endinterface

`default_nettype wire

// File: logic/key_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_config.svh"

module key_decode (
  input  wire                       frame_clk,
  input  wire                       rstN,
  input  game_input_pkg::scanCodeT  keycode,
  cmd_link_if.sender                link
);

  localparam int HoldW   = $clog2(`HOLD_MAX + 1);
  localparam int CreditW = $clog2(`CMD_QUEUE_DEPTH + 1);

  game_input_pkg::scanCodeT prevKey;
  logic [HoldW-1:0]         holdCount;
  logic                     holdSpent;
  logic [CreditW-1:0]       credits;
  logic                     pendValid;
  game_input_pkg::cmdT      pendCmd;

  logic                     spaceNow;
  logic                     spacePrev;
  logic                     autoRelease;
  logic                     spaceRelease;
  logic                     newValid;
  game_input_pkg::cmdT      newCmd;
  logic                     candValid;
  game_input_pkg::cmdT      candCmd;
  logic                     sendNow;

  assign spaceNow  = (keycode == game_input_pkg::KEY_SPACE);
  assign spacePrev = (prevKey == game_input_pkg::KEY_SPACE);

  // this frame is the HOLD_MAX-th one of the hold
  assign autoRelease  = spaceNow && !holdSpent && (holdCount == HoldW'(`HOLD_MAX - 1));
  // a hold that already fired gives nothing on release
  assign spaceRelease = spacePrev && !spaceNow && !holdSpent;

  // event of this frame
  // one key code at a time, so at most one edge pair can clash; restart first
  always_comb
  begin
    newValid = 1'b1;
    newCmd   = game_input_pkg::CMD_RESTART;
    if (keycode == game_input_pkg::KEY_RESTART && prevKey != game_input_pkg::KEY_RESTART)
      newCmd = game_input_pkg::CMD_RESTART;
    else if (autoRelease)
      newCmd = game_input_pkg::CMD_JUMP_LONG;
    else if (spaceRelease)
      newCmd = (holdCount < HoldW'(`HOLD_SHORT_MAX)) ? game_input_pkg::CMD_JUMP_SHORT
                                                     : game_input_pkg::CMD_JUMP_LONG;
    else if (keycode == game_input_pkg::KEY_DOWN && prevKey != game_input_pkg::KEY_DOWN)
      newCmd = game_input_pkg::CMD_DUCK_ON;
    else if (prevKey == game_input_pkg::KEY_DOWN && keycode != game_input_pkg::KEY_DOWN)
      newCmd = game_input_pkg::CMD_DUCK_OFF;
    else
      newValid = 1'b0;
  end

  // newer event replaces a pending one
  assign candValid = newValid || pendValid;
  assign candCmd   = newValid ? newCmd : pendCmd;
  assign sendNow   = candValid && (credits != '0);

  always_ff @(posedge frame_clk or negedge rstN)
  begin
    if (!rstN)
    begin
      prevKey       <= '0;
      holdCount     <= '0;
      holdSpent     <= 1'b0;
      credits       <= CreditW'(`CMD_QUEUE_DEPTH);
      pendValid     <= 1'b0;
      link.cmdValid <= 1'b0;
    end
    else
    begin
      prevKey <= keycode;
      // count held frames until the hold fires on its own
      if (spaceNow && !holdSpent)
      begin
        holdCount <= holdCount + 1'b1;
        holdSpent <= autoRelease;
      end
      else if (!spaceNow)
      begin
        holdCount <= '0;
        holdSpent <= 1'b0;
      end
      // spend on send, refill on return
      credits       <= credits - CreditW'(sendNow) + CreditW'(link.creditReturn);
      link.cmdValid <= sendNow;
      pendValid     <= candValid && !sendNow;
    end
  end

  // command payload, qualified by the valid bits
  always_ff @(posedge frame_clk)
  begin
    if (sendNow)
      link.cmd <= candCmd;
    if (candValid)
      pendCmd <= candCmd;
  end

endmodule

`default_nettype wire

// File: logic/dragon_motion.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_config.svh"

module dragon_motion (
  input  wire                        frame_clk,
  input  wire                        rstN,
  cmd_link_if.receiver               link,
  input  game_geom_pkg::gameStateT   gameState,
  output game_geom_pkg::coordT       dragonBottom,
  output logic                       ducking,
  output game_geom_pkg::coordT       cactusX,
  output logic                       restartSeen,
  output logic                       jumpSeen
);

  localparam int PtrW   = $clog2(`CMD_QUEUE_DEPTH);
  localparam int CountW = $clog2(`CMD_QUEUE_DEPTH + 1);

  game_input_pkg::cmdT     queue [`CMD_QUEUE_DEPTH];
  logic [PtrW-1:0]         wrPtr;
  logic [PtrW-1:0]         rdPtr;
  logic [CountW-1:0]       count;
  logic                    pop;
  game_input_pkg::cmdT     headCmd;

  game_geom_pkg::motionT   motion;
  game_geom_pkg::actionT   action;
  logic signed [11:0]      nextBottom;

  // one entry per frame while anything is queued
  assign pop               = (count != '0);
  assign link.creditReturn = pop;
  assign headCmd           = queue[rdPtr];

  // posture, airborne takes precedence
  assign action = (dragonBottom != game_geom_pkg::coordT'(`GROUND_Y)) ? game_geom_pkg::JUMP :
                  ducking ? game_geom_pkg::DUCK : game_geom_pkg::RUN;

  // where the bottom edge lands after this frame's motion
  assign nextBottom = $signed({2'b00, dragonBottom}) + motion;

  // queue storage
  always_ff @(posedge frame_clk)
  begin
    if (link.cmdValid)
      queue[wrPtr] <= link.cmd;
  end

  // queue pointers, credits keep count within depth
  always_ff @(posedge frame_clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (link.cmdValid)
        wrPtr <= (wrPtr == PtrW'(`CMD_QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PtrW'(`CMD_QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + CountW'(link.cmdValid) - CountW'(pop);
    end
  end

  // dragon and cactus, one step per frame
  always_ff @(posedge frame_clk or negedge rstN)
  begin
    if (!rstN)
    begin
      dragonBottom <= game_geom_pkg::coordT'(`GROUND_Y);
      motion       <= '0;
      ducking      <= 1'b0;
      cactusX      <= game_geom_pkg::coordT'(`SCREEN_W);
      restartSeen  <= 1'b0;
      jumpSeen     <= 1'b0;
    end
    else
    begin
      restartSeen <= 1'b0;
      jumpSeen    <= 1'b0;
      if (pop && headCmd == game_input_pkg::CMD_RESTART)
      begin
        // back to the reset picture, state does not matter
        dragonBottom <= game_geom_pkg::coordT'(`GROUND_Y);
        motion       <= '0;
        ducking      <= 1'b0;
        cactusX      <= game_geom_pkg::coordT'(`SCREEN_W);
        restartSeen  <= 1'b1;
      end
      else
      begin
        // referee still shows GAME in the frame after a restart
        if (gameState == game_geom_pkg::GAME && !restartSeen)
        begin
          // gravity step
          if (nextBottom >= `GROUND_Y)
          begin
            dragonBottom <= game_geom_pkg::coordT'(`GROUND_Y);
            motion       <= '0;
          end
          else
          begin
            dragonBottom <= nextBottom[9:0];
            motion       <= motion + game_geom_pkg::motionT'(`GRAVITY);
          end
          // scroll left, wrap before passing column 0
          if (cactusX < `CACTUS_SPEED)
            cactusX <= game_geom_pkg::coordT'(`SCREEN_W);
          else
            cactusX <= cactusX - game_geom_pkg::coordT'(`CACTUS_SPEED);
        end
        // popped command, a launch overrides the gravity step
        if (pop)
        begin
          unique case (headCmd)
            game_input_pkg::CMD_JUMP_SHORT:
            begin
              jumpSeen <= 1'b1;
              if (action != game_geom_pkg::JUMP)
                motion <= game_geom_pkg::motionT'(-(`JUMP_SHORT));
            end
            game_input_pkg::CMD_JUMP_LONG:
            begin
              jumpSeen <= 1'b1;
              if (action != game_geom_pkg::JUMP)
                motion <= game_geom_pkg::motionT'(-(`JUMP_LONG));
            end
            game_input_pkg::CMD_DUCK_ON:
              ducking <= 1'b1;
            game_input_pkg::CMD_DUCK_OFF:
              ducking <= 1'b0;
            default:
              ducking <= ducking;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/game_referee.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_config.svh"

module game_referee (
  input  wire                        frame_clk,
  input  wire                        rstN,
  input  game_geom_pkg::coordT       dragonBottom,
  input  wire                        ducking,
  input  game_geom_pkg::coordT       cactusX,
  input  wire                        restartSeen,
  input  wire                        jumpSeen,
  output game_geom_pkg::gameStateT   gameState,
  output logic                       running,
  output logic                       dead,
  output game_geom_pkg::scoreT       score
);

  // fixed edges of both boxes
  localparam game_geom_pkg::coordT DragonLeft  =
    game_geom_pkg::coordT'(`DRAGON_X - `DRAGON_W / 2);
  localparam game_geom_pkg::coordT DragonRight =
    game_geom_pkg::coordT'(`DRAGON_X + `DRAGON_W / 2);
  localparam game_geom_pkg::coordT CactusTop   =
    game_geom_pkg::coordT'(`GROUND_Y - `CACTUS_H);
  localparam game_geom_pkg::coordT CactusBase  =
    game_geom_pkg::coordT'(`GROUND_Y);

  game_geom_pkg::gameStateT stateNext;
  game_geom_pkg::coordT     dragonTop;
  game_geom_pkg::coordT     cactusRight;
  logic                     overlap;

  // ducking lowers the top edge
  assign dragonTop   = dragonBottom - (ducking ? game_geom_pkg::coordT'(`DUCK_H)
                                               : game_geom_pkg::coordT'(`DRAGON_H));
  assign cactusRight = cactusX + game_geom_pkg::coordT'(`CACTUS_W);

  // strict intersection on both axes, touching edges are safe
  assign overlap = (DragonLeft < cactusRight) && (cactusX < DragonRight) &&
                   (dragonTop < CactusBase) && (CactusTop < dragonBottom);

  always_comb
  begin
    stateNext = gameState;
    unique case (gameState)
      game_geom_pkg::START:
        if (jumpSeen)
          stateNext = game_geom_pkg::GAME;
      game_geom_pkg::GAME:
        // restart beats a hit in the same frame
        if (restartSeen)
          stateNext = game_geom_pkg::START;
        else if (overlap)
          stateNext = game_geom_pkg::OVER;
      game_geom_pkg::OVER:
        if (restartSeen)
          stateNext = game_geom_pkg::START;
      default:
        stateNext = game_geom_pkg::START;
    endcase
  end

  always_ff @(posedge frame_clk or negedge rstN)
  begin
    if (!rstN)
    begin
      gameState <= game_geom_pkg::START;
      score     <= '0;
    end
    else
    begin
      gameState <= stateNext;
      // one point per frame in play, frozen once over
      if (restartSeen)
        score <= '0;
      else if (gameState == game_geom_pkg::GAME)
        score <= score + 1'b1;
    end
  end

  // status decoded from the state register
  assign running = (gameState == game_geom_pkg::GAME);
  assign dead    = (gameState == game_geom_pkg::OVER);

endmodule

`default_nettype wire

// File: logic/game_control.sv
`timescale 1ns/1ns
`default_nettype none

module game_control (
  input  wire                       frame_clk,
  input  wire                       rstN,
  input  game_input_pkg::scanCodeT  keycode,
  output logic                      running,
  output logic                      dead,
  output game_geom_pkg::coordT      dragonBottom,
  output logic                      ducking,
  output game_geom_pkg::coordT      cactusX,
  output game_geom_pkg::scoreT      score
);

  // frame snapshot back from the referee
  game_geom_pkg::gameStateT gameState;
  // one-frame pulses from motion
  logic                     restartSeen;
  logic                     jumpSeen;

  // decode to motion
  cmd_link_if link ();

  key_decode uKeyDecode (
    .frame_clk (frame_clk),
    .rstN      (rstN),
    .keycode   (keycode),
    .link      (link.sender)
  );

  dragon_motion uDragonMotion (
    .frame_clk    (frame_clk),
    .rstN         (rstN),
    .link         (link.receiver),
    .gameState    (gameState),
    .dragonBottom (dragonBottom),
    .ducking      (ducking),
    .cactusX      (cactusX),
    .restartSeen  (restartSeen),
    .jumpSeen     (jumpSeen)
  );

  game_referee uGameReferee (
    .frame_clk    (frame_clk),
    .rstN         (rstN),
    .dragonBottom (dragonBottom),
    .ducking      (ducking),
    .cactusX      (cactusX),
    .restartSeen  (restartSeen),
    .jumpSeen     (jumpSeen),
    .gameState    (gameState),
    .running      (running),
    .dead         (dead),
    .score        (score)
  );

endmodule

`default_nettype wire

// File: verification/game_control_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_config.svh"

module game_control_tb;

  // upper bound on any single wait, in frames
  localparam int WaitLimit    = 400;
  // frames of steady ducking that show the link has drained
  localparam int SettleFrames = `CMD_QUEUE_DEPTH + 4;

  logic                     frame_clk;
  logic                     rstN;
  game_input_pkg::scanCodeT keycode;
  logic                     running;
  logic                     dead;
  game_geom_pkg::coordT     dragonBottom;
  logic                     ducking;
  game_geom_pkg::coordT     cactusX;
  game_geom_pkg::scoreT     score;

  game_control dut (
    .frame_clk    (frame_clk),
    .rstN         (rstN),
    .keycode      (keycode),
    .running      (running),
    .dead         (dead),
    .dragonBottom (dragonBottom),
    .ducking      (ducking),
    .cactusX      (cactusX),
    .score        (score)
  );

  // 8 ns frame clock
  initial
  begin
    frame_clk = 1'b0;
    forever #4 frame_clk = ~frame_clk;
  end

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string what, input int got, input int want);
    assert (got == want)
    else
      failNow($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, want));
  endtask

  task automatic checkTrue(input bit cond, input string msg);
    assert (cond)
    else
      failNow(msg);
  endtask

  // highest point of a jump, from launch speed and gravity
  // returned as the smallest bottom row reached
  function automatic int peakBottom(input int launch);
    int bottom;
    int speed;
    int lowest;
    bottom = `GROUND_Y;
    speed  = -launch;
    lowest = bottom;
    // stops on the frame that would reach the ground
    while (bottom + speed < `GROUND_Y)
    begin
      bottom = bottom + speed;
      speed  = speed + `GRAVITY;
      if (bottom < lowest)
        lowest = bottom;
    end
    return lowest;
  endfunction

  // strict box intersection on both axes
  function automatic bit boxesOverlap(input int bottom, input bit duck, input int x);
    int dragonTop;
    dragonTop = bottom - (duck ? `DUCK_H : `DRAGON_H);
    return (`DRAGON_X - `DRAGON_W / 2 < x + `CACTUS_W) && (x < `DRAGON_X + `DRAGON_W / 2) &&
           (dragonTop < `GROUND_Y) && (`GROUND_Y - `CACTUS_H < bottom);
  endfunction

  // key seen by the DUT on exactly that many edges
  task automatic holdKey(input game_input_pkg::scanCodeT key, input int frames);
    @(posedge frame_clk);
    keycode <= key;
    repeat (frames) @(posedge frame_clk);
    keycode <= '0;
  endtask

  // short press after a random gap
  task automatic tapSpace();
    int gap;
    gap = $urandom % 4;
    repeat (gap) @(posedge frame_clk);
    holdKey(game_input_pkg::KEY_SPACE, 1 + $urandom % (`HOLD_SHORT_MAX - 1));
  endtask

  task automatic waitRunning();
    int n;
    n = 0;
    @(negedge frame_clk);
    while (!running && n < WaitLimit)
    begin
      @(negedge frame_clk);
      n++;
    end
    checkTrue(running, "Timeout waiting for the game to start");
  endtask

  task automatic waitDucking(input bit want);
    int n;
    n = 0;
    @(negedge frame_clk);
    while (ducking != want && n < WaitLimit)
    begin
      @(negedge frame_clk);
      n++;
    end
    checkTrue(ducking == want, "Timeout waiting for ducking to follow the down key");
  endtask

  // picture right after reset or restart
  task automatic checkResetPicture();
    checkValue("running", running, 0);
    checkValue("dead", dead, 0);
    checkValue("dragonBottom", dragonBottom, `GROUND_Y);
    checkValue("cactusX", cactusX, `SCREEN_W);
    checkValue("score", score, 0);
    checkValue("ducking", ducking, 0);
  endtask

  // referee leaves GAME or OVER one frame after the restart
  task automatic restartGame();
    int n;
    holdKey(game_input_pkg::KEY_RESTART, 1);
    n = 0;
    @(negedge frame_clk);
    while ((running || dead || score != 0) && n < WaitLimit)
    begin
      @(negedge frame_clk);
      n++;
    end
    checkTrue(!running && !dead, "Timeout waiting for the restart to take effect");
    checkResetPicture();
  endtask

  // checks every frame against the overlap rule until the hit
  task automatic runUntilHit();
    bit hitSeen;
    bit hit;
    int n;
    hitSeen = 1'b0;
    hit     = 1'b0;
    n       = 0;
    while (!hit && n < WaitLimit)
    begin
      @(negedge frame_clk);
      if (hitSeen)
      begin
        // one frame after the overlapping snapshot
        checkValue("dead after overlap", dead, 1);
        checkValue("running after overlap", running, 0);
        hit = 1'b1;
      end
      else
      begin
        checkValue("dead before overlap", dead, 0);
        checkValue("running before overlap", running, 1);
        hitSeen = boxesOverlap(dragonBottom, ducking, cactusX);
      end
      n++;
    end
    checkTrue(hit, "Timeout waiting for the cactus to reach the dragon");
  endtask

  // lowest bottom row between takeoff and landing
  // also whether space was still down at takeoff
  task automatic measureApex(output int lowest, output bit heldAtTakeoff);
    int n;
    n      = 0;
    lowest = `GROUND_Y;
    @(negedge frame_clk);
    while (dragonBottom == `GROUND_Y && n < WaitLimit)
    begin
      @(negedge frame_clk);
      n++;
    end
    checkTrue(dragonBottom != `GROUND_Y, "Timeout waiting for the dragon to take off");
    heldAtTakeoff = (keycode == game_input_pkg::KEY_SPACE);
    n = 0;
    while (dragonBottom != `GROUND_Y && n < WaitLimit)
    begin
      if (dragonBottom < lowest)
        lowest = dragonBottom;
      @(negedge frame_clk);
      n++;
    end
    checkTrue(dragonBottom == `GROUND_Y, "Timeout waiting for the dragon to land");
  endtask

  task automatic testStartScroll();
    int prevX;
    int prevScore;
    tapSpace();
    waitRunning();
    prevX     = cactusX;
    prevScore = score;
    repeat (24)
    begin
      @(negedge frame_clk);
      checkValue("cactusX while running", cactusX,
                 (prevX < `CACTUS_SPEED) ? `SCREEN_W : prevX - `CACTUS_SPEED);
      checkValue("score while running", score, prevScore + 1);
      prevX     = cactusX;
      prevScore = score;
    end
  endtask

  // the jump itself starts the game from START
  task automatic testJump(input int frames, input int launch);
    int apex;
    bit held;
    restartGame();
    // hold may outlast the takeoff, so measure alongside
    fork
      holdKey(game_input_pkg::KEY_SPACE, frames);
      measureApex(apex, held);
    join
    checkValue($sformatf("lowest dragonBottom after %0d held frames", frames),
               apex, peakBottom(launch));
    // only a hold reaching the limit launches before release
    checkValue($sformatf("space held at takeoff after %0d held frames", frames),
               held, frames >= `HOLD_MAX);
  endtask

  task automatic testCollision();
    int heldScore;
    restartGame();
    tapSpace();
    waitRunning();
    runUntilHit();
    heldScore = score;
    // frozen once over
    repeat (16)
    begin
      @(negedge frame_clk);
      checkValue("score after death", score, heldScore);
      checkValue("dead after death", dead, 1);
    end
  endtask

  // overlap model takes the ducking height while down is held
  task automatic testDucking();
    restartGame();
    tapSpace();
    waitRunning();
    @(posedge frame_clk);
    keycode <= game_input_pkg::KEY_DOWN;
    waitDucking(1'b1);
    runUntilHit();
    @(posedge frame_clk);
    keycode <= '0;
    waitDucking(1'b0);
  endtask

  task automatic testRestart();
    // from OVER
    restartGame();
    // from GAME
    tapSpace();
    waitRunning();
    restartGame();
  endtask

  // down edges on every frame, more than the queue holds
  task automatic testBackPressure();
    int edges;
    int frozenX;
    int stable;
    int n;
    int i;
    bit wantDuck;
    edges    = `CMD_QUEUE_DEPTH + 1 + $urandom % 8;
    frozenX  = cactusX;
    wantDuck = (edges % 2 == 1);
    for (i = 0; i < edges; i++)
    begin
      @(posedge frame_clk);
      if (i % 2 == 0)
        keycode <= game_input_pkg::KEY_DOWN;
      else
        keycode <= '0;
    end
    // last edge wins once nothing is left in flight
    stable = 0;
    n      = 0;
    while (stable < SettleFrames && n < WaitLimit)
    begin
      @(negedge frame_clk);
      checkValue("running during burst", running, 0);
      checkValue("dead during burst", dead, 0);
      stable = (ducking == wantDuck) ? stable + 1 : 0;
      n++;
    end
    checkTrue(stable >= SettleFrames, "Timeout waiting for the command link to drain");
    checkValue("ducking after burst", ducking, wantDuck);
    // still in START, nothing moved
    checkValue("running after burst", running, 0);
    checkValue("dead after burst", dead, 0);
    checkValue("dragonBottom after burst", dragonBottom, `GROUND_Y);
    checkValue("cactusX after burst", cactusX, frozenX);
    checkValue("score after burst", score, 0);
    @(posedge frame_clk);
    keycode <= '0;
  endtask

  initial
  begin
    void'($urandom(32'h8ff8_db22));
    rstN    = 1'b0;
    keycode = '0;
    repeat (10) @(posedge frame_clk);
    rstN <= 1'b1;
    @(negedge frame_clk);
    checkResetPicture();
    testStartScroll();
    // short, long, and auto release well before the key comes up
    testJump(1 + $urandom % (`HOLD_SHORT_MAX - 1), `JUMP_SHORT);
    testJump(`HOLD_SHORT_MAX + $urandom % (`HOLD_MAX - `HOLD_SHORT_MAX), `JUMP_LONG);
    testJump(`HOLD_MAX + 20 + $urandom % 20, `JUMP_LONG);
    testCollision();
    testDucking();
    testRestart();
    testBackPressure();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/game_geom_pkg.sv
logic/game_input_pkg.sv
logic/cmd_link_if.sv
logic/key_decode.sv
logic/dragon_motion.sv
logic/game_referee.sv
logic/game_control.sv
verification/game_control_tb.sv

// File: Bender.yml
package:
  name: game_control

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/game_geom_pkg.sv
      - logic/game_input_pkg.sv
      - logic/cmd_link_if.sv
      - logic/key_decode.sv
      - logic/dragon_motion.sv
      - logic/game_referee.sv
      - logic/game_control.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/game_control_tb.sv
